// File: filelist.f
+incdir+include
rtl/tx_frontend_pkg.sv
rtl/setting_reg.sv
rtl/mult_add_clip.sv
rtl/iq_compensator.sv
rtl/add2_and_clip_reg.sv
rtl/round_sd.sv
rtl/tx_frontend.sv
sim/tb_tx_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the tx_frontend testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tx_frontend \
  -f filelist.f \
  -o sim_tx_frontend

# A failing run exits nonzero, the log search below gives the verdict
./obj_dir/sim_tx_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// File: sim/tb_tx_frontend.sv
/* Testbench for the transmit front end: clock, reset, LCG stimulus,
   reference model and assertion checks */

`timescale 1ns/1ns
`default_nettype none

`include "tx_frontend_macros.svh"

module tb_tx_frontend;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_SAMPLES  = 200;
  localparam int WATCHDOG_NS  = (NUM_SAMPLES * 8 + RESET_CYCLES) * CLK_PERIOD;
  localparam longint WIDE_MAX = 64'sd8388607;
  localparam longint WIDE_MIN = -64'sd8388608;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       set_stb_i;
  logic [`TXF_SET_ADDR_W-1:0] set_addr_i;
  logic [`TXF_SET_DATA_W-1:0] set_data_i;
  logic                       tx_stb_i;
  logic signed [15:0]         tx_i_i;
  logic signed [15:0]         tx_q_i;
  logic                       dac_stb_o;
  logic signed [15:0]         dac_i_o;
  logic signed [15:0]         dac_q_o;

  // Model copy of the settings and the two residues
  logic signed [23:0] m_ofs_i = '0;
  logic signed [23:0] m_ofs_q = '0;
  logic signed [17:0] m_mag = '0;
  logic signed [17:0] m_phase = '0;
  logic [7:0]         m_mux = `TXF_MUX_RESET;
  longint             m_err_i = 0;
  longint             m_err_q = 0;

  // Expected {I, Q} pairs in output order
  logic [31:0]        exp_queue[$];
  logic               exp_avail = 1'b0;
  logic signed [15:0] exp_head_i = '0;
  logic signed [15:0] exp_head_q = '0;

  logic [31:0] lcg_state = 32'h186c;
  logic        rst_seen = 1'b0;
  int          error_count = 0;

  logic signed [15:0] full_scale [0:7] = '{16'sh7fff, 16'sh8000, 16'sh4000, 16'shc000,
                                           16'sh0001, 16'shffff, 16'sh7ffe, 16'sh8001};
  logic [7:0] mux_values [0:4] = '{8'h00, 8'h01, 8'h11, 8'h10, 8'h51};

  tx_frontend DUT (
    .clk        (clk),
    .reset      (reset),
    .set_stb_i  (set_stb_i),
    .set_addr_i (set_addr_i),
    .set_data_i (set_data_i),
    .tx_stb_i   (tx_stb_i),
    .tx_i_i     (tx_i_i),
    .tx_q_i     (tx_q_i),
    .dac_stb_o  (dac_stb_o),
    .dac_i_o    (dac_i_o),
    .dac_q_o    (dac_q_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (reset) begin
      rst_seen <= 1'b1;
    end
  end

  task automatic stop_failed();
    error_count++;
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Random bits above the payload, the register must ignore them
  function automatic logic [31:0] with_junk(input logic [31:0] value, input int width);
    logic [31:0] mask;
    mask = (32'h1 << width) - 32'h1;
    return (next_rand() & ~mask) | (value & mask);
  endfunction

  function automatic longint clip_wide(input longint v);
    return (v > WIDE_MAX) ? WIDE_MAX : ((v < WIDE_MIN) ? WIDE_MIN : v);
  endfunction

  // s * c + s with 32 fraction bits, floored to 23 fraction bits
  function automatic longint iq_term(input longint s, input longint c);
    longint acc;
    acc = s * c + s * 131072;
    return clip_wide(acc >>> 9);
  endfunction

  // Round half up with residue feedback, a clipped output clears the residue
  task automatic round_model(input longint x, inout longint err, output longint y);
    longint sum;
    longint q;
    sum = x + err;
    q = (sum + 128) >>> 8;
    if (q > 32767) begin
      y = 32767;
      err = 0;
    end else if (q < -32768) begin
      y = -32768;
      err = 0;
    end else begin
      y = q;
      err = sum - q * 256;
    end
  endtask

  function automatic longint lane_select(input logic [3:0] sel, input longint i_val,
                                         input longint q_val);
    if (sel == 4'd0) begin
      return i_val;
    end
    if (sel == 4'd1) begin
      return q_val;
    end
    return 0;
  endfunction

  task automatic push_expected(input logic signed [15:0] i_val,
                               input logic signed [15:0] q_val);
    longint wi;
    longint wq;
    longint ri;
    longint rq;
    longint di;
    longint dq;
    wi = clip_wide(iq_term(i_val, m_mag) + m_ofs_i);
    wq = clip_wide(iq_term(q_val, m_phase) + m_ofs_q);
    round_model(wi, m_err_i, ri);
    round_model(wq, m_err_q, rq);
    di = lane_select(m_mux[3:0], ri, rq);
    dq = lane_select(m_mux[7:4], ri, rq);
    exp_queue.push_back({di[15:0], dq[15:0]});
  endtask

  task automatic send_sample(input logic stb, input logic signed [15:0] i_val,
                             input logic signed [15:0] q_val);
    @(posedge clk);
    tx_stb_i <= stb;
    tx_i_i   <= i_val;
    tx_q_i   <= q_val;
    if (stb) begin
      push_expected(i_val, q_val);
    end
  endtask

  task automatic send_random(input int count);
    logic [31:0] r;
    logic [31:0] s;
    for (int k = 0; k < count; k++) begin
      r = next_rand();
      if (r[31:30] == 2'b00) begin
        send_sample(1'b0, r[23:8], r[15:0]);
      end
      r = next_rand();
      s = next_rand();
      send_sample(1'b1, r[31:16], s[31:16]);
    end
  endtask

  task automatic send_constant(input int count, input logic signed [15:0] i_val,
                               input logic signed [15:0] q_val);
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
      r = next_rand();
      // Idle cycles carry junk and must leave the residue alone
      if (r[31]) begin
        send_sample(1'b0, r[15:0], r[30:15]);
      end
      send_sample(1'b1, i_val, q_val);
    end
  endtask

  task automatic write_setting(input int addr, input logic [31:0] data);
    @(posedge clk);
    set_stb_i  <= 1'b1;
    set_addr_i <= addr[7:0];
    set_data_i <= data;
    case (addr)
      `TXF_SR_OFFSET_I:   m_ofs_i = data[23:0];
      `TXF_SR_OFFSET_Q:   m_ofs_q = data[23:0];
      `TXF_SR_MAG_CORR:   m_mag = data[17:0];
      `TXF_SR_PHASE_CORR: m_phase = data[17:0];
      `TXF_SR_MUX:        m_mux = data[7:0];
      default:            m_mux = m_mux;
    endcase
  endtask

  task automatic finish_writes();
    @(posedge clk);
    set_stb_i  <= 1'b0;
    set_addr_i <= `TXF_SR_MUX;
    set_data_i <= next_rand();
  endtask

  task automatic drain_pipeline();
    @(posedge clk);
    tx_stb_i <= 1'b0;
    while (exp_queue.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  // Retire the checked pair and present the next one
  always @(posedge clk) begin
    if (!reset && dac_stb_o && exp_queue.size() > 0) begin
      void'(exp_queue.pop_front());
    end
    exp_avail <= (exp_queue.size() > 0);
    if (exp_queue.size() > 0) begin
      exp_head_i <= exp_queue[0][31:16];
      exp_head_q <= exp_queue[0][15:0];
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk) (reset && rst_seen) |-> !dac_stb_o)
    else report_problem("DAC strobe was high while reset was held");

  a_stb_latency: assert property (@(posedge clk) disable iff (reset)
    dac_stb_o == $past(tx_stb_i, 5))
    else report_mismatch($sformatf("dac_stb_o is %b, not the input strobe of 5 cycles before",
      $sampled(dac_stb_o)));

  a_expect_ready: assert property (@(posedge clk) disable iff (reset)
    dac_stb_o |-> exp_avail)
    else report_problem("DAC strobe arrived with no expected sample left");

  a_dac_i: assert property (@(posedge clk) disable iff (reset)
    (dac_stb_o && exp_avail) |-> (dac_i_o == exp_head_i))
    else report_mismatch($sformatf("dac_i_o is %h, expected %h",
      $sampled(dac_i_o), $sampled(exp_head_i)));

  a_dac_q: assert property (@(posedge clk) disable iff (reset)
    (dac_stb_o && exp_avail) |-> (dac_q_o == exp_head_q))
    else report_mismatch($sformatf("dac_q_o is %h, expected %h",
      $sampled(dac_q_o), $sampled(exp_head_q)));

  initial begin
    #(WATCHDOG_NS);
    report_problem($sformatf("Timeout: the run was still busy after %0d ns", WATCHDOG_NS));
  end

  initial begin
    reset      = 1'b1;
    set_stb_i  = 1'b0;
    set_addr_i = '0;
    set_data_i = '0;
    tx_stb_i   = 1'b0;
    tx_i_i     = '0;
    tx_q_i     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Reset settings are neutral, samples pass unchanged
    send_random(64);
    drain_pipeline();

    // Random correction terms
    write_setting(`TXF_SR_MAG_CORR, next_rand());
    write_setting(`TXF_SR_PHASE_CORR, next_rand());
    finish_writes();
    send_random(32);
    drain_pipeline();

    // Near +1 doubles I and clips full scale, -0.5 halves Q
    write_setting(`TXF_SR_MAG_CORR, with_junk(32'h1ffff, 18));
    write_setting(`TXF_SR_PHASE_CORR, with_junk(32'h30000, 18));
    finish_writes();
    for (int k = 0; k < 8; k++) begin
      send_sample(1'b1, full_scale[k], full_scale[7 - k]);
    end
    drain_pipeline();

    // Opposite offsets per channel
    write_setting(`TXF_SR_MAG_CORR, with_junk(32'h0, 18));
    write_setting(`TXF_SR_PHASE_CORR, with_junk(32'h0, 18));
    write_setting(`TXF_SR_OFFSET_I, with_junk(32'h012345, 24));
    write_setting(`TXF_SR_OFFSET_Q, with_junk(32'hf54322, 24));
    finish_writes();
    send_random(16);
    drain_pipeline();

    // Offsets at both rails
    write_setting(`TXF_SR_OFFSET_I, with_junk(32'h7fffff, 24));
    write_setting(`TXF_SR_OFFSET_Q, with_junk(32'h800000, 24));
    finish_writes();
    send_random(16);
    drain_pipeline();

    // Half an output step on I, odd fraction on Q
    write_setting(`TXF_SR_OFFSET_I, with_junk(32'h000080, 24));
    write_setting(`TXF_SR_OFFSET_Q, with_junk(32'hffff40, 24));
    finish_writes();
    send_constant(24, 16'sh1000, -16'sh0200);
    drain_pipeline();

    write_setting(`TXF_SR_OFFSET_I, with_junk(32'h0, 24));
    write_setting(`TXF_SR_OFFSET_Q, with_junk(32'h0, 24));
    finish_writes();
    for (int m = 0; m < 5; m++) begin
      write_setting(`TXF_SR_MUX, with_junk({24'h0, mux_values[m]}, 8));
      finish_writes();
      send_random(8);
      drain_pipeline();
    end

    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_failed();
    end
  end

endmodule

`default_nettype wire

// File: rtl/tx_frontend.sv
/* Transmit front end: settings registers, I/Q correction, DC offset,
   sigma-delta rounding and the DAC lane mux */

`timescale 1ns/1ns
`default_nettype none

`include "tx_frontend_macros.svh"

module tx_frontend #(
  parameter bit BYPASS_IQ_COMP        = `TXF_BYPASS_IQ_COMP,
  parameter bit BYPASS_DC_OFFSET_CORR = `TXF_BYPASS_DC_OFFSET_CORR
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set_stb_i,
  input  logic [`TXF_SET_ADDR_W-1:0] set_addr_i,
  input  logic [`TXF_SET_DATA_W-1:0] set_data_i,
  input  logic                       tx_stb_i,
  input  tx_frontend_pkg::sample_t   tx_i_i,
  input  tx_frontend_pkg::sample_t   tx_q_i,
  output logic                       dac_stb_o,
  output tx_frontend_pkg::sample_t   dac_i_o,
  output tx_frontend_pkg::sample_t   dac_q_o
);

  tx_frontend_pkg::wide_t     dco_i, dco_q;
  tx_frontend_pkg::corr_t     mag_corr, phase_corr;
  tx_frontend_pkg::mux_ctrl_t mux_ctrl;

  logic                     comp_stb, ofs_stb, round_stb;
  tx_frontend_pkg::wide_t   comp_i, comp_q, ofs_i, ofs_q;
  tx_frontend_pkg::sample_t round_i, round_q;

  // Settings registers
  setting_reg #(
    .payload_t (tx_frontend_pkg::wide_t),
    .ADDR      (`TXF_SR_OFFSET_I)
  ) sr_offset_i (
    .clk (clk), .reset (reset), .set_stb_i (set_stb_i),
    .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (dco_i)
  );

  setting_reg #(
    .payload_t (tx_frontend_pkg::wide_t),
    .ADDR      (`TXF_SR_OFFSET_Q)
  ) sr_offset_q (
    .clk (clk), .reset (reset), .set_stb_i (set_stb_i),
    .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (dco_q)
  );

  setting_reg #(
    .payload_t (tx_frontend_pkg::corr_t),
    .ADDR      (`TXF_SR_MAG_CORR)
  ) sr_mag_corr (
    .clk (clk), .reset (reset), .set_stb_i (set_stb_i),
    .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (mag_corr)
  );

  setting_reg #(
    .payload_t (tx_frontend_pkg::corr_t),
    .ADDR      (`TXF_SR_PHASE_CORR)
  ) sr_phase_corr (
    .clk (clk), .reset (reset), .set_stb_i (set_stb_i),
    .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (phase_corr)
  );

  setting_reg #(
    .payload_t (tx_frontend_pkg::mux_ctrl_t),
    .ADDR      (`TXF_SR_MUX),
    .RESET_VAL (tx_frontend_pkg::mux_ctrl_t'(`TXF_MUX_RESET))
  ) sr_mux (
    .clk (clk), .reset (reset), .set_stb_i (set_stb_i),
    .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (mux_ctrl)
  );

  // I/Q imbalance correction, 2 cycles
  iq_compensator #(.BYPASS (BYPASS_IQ_COMP)) iq_comp (
    .clk          (clk),
    .reset        (reset),
    .stb_i        (tx_stb_i),
    .i_i          (tx_i_i),
    .q_i          (tx_q_i),
    .mag_corr_i   (mag_corr),
    .phase_corr_i (phase_corr),
    .stb_o        (comp_stb),
    .i_o          (comp_i),
    .q_o          (comp_q)
  );

  // DC offset, 1 cycle
  generate
    if (!BYPASS_DC_OFFSET_CORR) begin : g_dco
      add2_and_clip_reg add_dco_i (
        .clk (clk), .reset (reset), .stb_i (comp_stb),
        .a_i (dco_i), .b_i (comp_i), .stb_o (ofs_stb), .sum_o (ofs_i)
      );
      add2_and_clip_reg add_dco_q (
        .clk (clk), .reset (reset), .stb_i (comp_stb),
        .a_i (dco_q), .b_i (comp_q), .stb_o (), .sum_o (ofs_q)
      );
    end else begin : g_no_dco
      assign ofs_stb = comp_stb;
      assign ofs_i   = comp_i;
      assign ofs_q   = comp_q;
    end
  endgenerate

  // Back to 16 bits, 1 cycle
  round_sd round_sd_i (
    .clk (clk), .reset (reset), .stb_i (ofs_stb), .in_i (ofs_i),
    .stb_o (round_stb), .out_o (round_i)
  );
  round_sd round_sd_q (
    .clk (clk), .reset (reset), .stb_i (ofs_stb), .in_i (ofs_q),
    .stb_o (), .out_o (round_q)
  );

  // Lane mux, 0 picks I, 1 picks Q, other codes send zero
  always_ff @(posedge clk) begin
    if (reset) begin
      dac_stb_o <= 1'b0;
      dac_i_o   <= '0;
      dac_q_o   <= '0;
    end else begin
      dac_stb_o <= round_stb;
      case (mux_ctrl.i_sel)
        tx_frontend_pkg::MUX_SEL_I: dac_i_o <= round_i;
        tx_frontend_pkg::MUX_SEL_Q: dac_i_o <= round_q;
        default:                    dac_i_o <= '0;
      endcase
      case (mux_ctrl.q_sel)
        tx_frontend_pkg::MUX_SEL_I: dac_q_o <= round_i;
        tx_frontend_pkg::MUX_SEL_Q: dac_q_o <= round_q;
        default:                    dac_q_o <= '0;
      endcase
    end
  end

  a_no_stb_after_reset: assert property (@(posedge clk)
    $fell(reset) |=> !$rose(dac_stb_o));

endmodule

`default_nettype wire

// File: rtl/round_sd.sv
/* Sigma-delta rounding from Q1.23 to Q1.15 with residue feedback,
   rounding half up and saturation */

`timescale 1ns/1ns
`default_nettype none

`include "tx_frontend_macros.svh"

module round_sd (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stb_i,
  input  tx_frontend_pkg::wide_t   in_i,
  output logic                     stb_o,
  output tx_frontend_pkg::sample_t out_o
);

  localparam int DROP = `TXF_FRAC_DROP;
  localparam int HALF = 1 << (DROP - 1);

  // Residue left over from the last strobed sample
  logic signed [DROP:0] err_q;

  logic signed [24:0] sum_w;
  logic signed [25:0] rnd_w;
  logic signed [17:0] quo_w;
  logic               clip_w;
  tx_frontend_pkg::sample_t out_w;
  logic signed [24:0] resid_w;

  assign sum_w = in_i + err_q;

  // Half up: add half a step, then floor
  assign rnd_w = sum_w + 26'sd128;
  assign quo_w = rnd_w[25:DROP];

  always_comb begin
    clip_w = 1'b1;
    if (quo_w[17:15] == 3'b000 || quo_w[17:15] == 3'b111) begin
      clip_w = 1'b0;
      out_w  = quo_w[15:0];
    end else if (quo_w[17]) begin
      out_w = 16'sh8000;
    end else begin
      out_w = 16'sh7fff;
    end
  end

  // What the output misses of the sum
  assign resid_w = sum_w - {out_w[15], out_w, {DROP{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
      out_o <= '0;
      err_q <= '0;
    end else begin
      stb_o <= stb_i;
      if (stb_i) begin
        out_o <= out_w;
        // A clipped output carries no residue forward
        err_q <= clip_w ? '0 : resid_w[DROP:0];
      end
    end
  end

  a_resid_range: assert property (@(posedge clk) disable iff (reset)
    (err_q >= -HALF) && (err_q < HALF));

endmodule

`default_nettype wire

// File: rtl/add2_and_clip_reg.sv
/* Registered saturating adder for wide samples with strobe */

`timescale 1ns/1ns
`default_nettype none

module add2_and_clip_reg (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stb_i,
  input  tx_frontend_pkg::wide_t a_i,
  input  tx_frontend_pkg::wide_t b_i,
  output logic                   stb_o,
  output tx_frontend_pkg::wide_t sum_o
);

  logic signed [24:0] sum_w;
  tx_frontend_pkg::wide_t sat_w;

  assign sum_w = a_i + b_i;

  // Overflow shows as a carry into the extra sign bit
  always_comb begin
    if (sum_w[24] == sum_w[23]) begin
      sat_w = sum_w[23:0];
    end else if (sum_w[24]) begin
      sat_w = {1'b1, {23{1'b0}}};
    end else begin
      sat_w = {1'b0, {23{1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
      sum_o <= '0;
    end else begin
      stb_o <= stb_i;
      sum_o <= sat_w;
    end
  end

endmodule

`default_nettype wire

// File: rtl/iq_compensator.sv
/* I/Q imbalance correction with magnitude and phase terms,
   matching strobe delay and a bypass option */

`timescale 1ns/1ns
`default_nettype none

`include "tx_frontend_macros.svh"

module iq_compensator #(
  parameter bit BYPASS = 1'b0
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stb_i,
  input  tx_frontend_pkg::sample_t i_i,
  input  tx_frontend_pkg::sample_t q_i,
  input  tx_frontend_pkg::corr_t   mag_corr_i,
  input  tx_frontend_pkg::corr_t   phase_corr_i,
  output logic                     stb_o,
  output tx_frontend_pkg::wide_t   i_o,
  output tx_frontend_pkg::wide_t   q_o
);

  generate
    if (!BYPASS) begin : g_comp
      logic [1:0] stb_dly;

      // I gets the magnitude term, Q the phase term
      mult_add_clip mult_i (
        .clk   (clk),
        .reset (reset),
        .a_i   (i_i),
        .b_i   (mag_corr_i),
        .c_i   (i_i),
        .o_o   (i_o)
      );

      mult_add_clip mult_q (
        .clk   (clk),
        .reset (reset),
        .a_i   (q_i),
        .b_i   (phase_corr_i),
        .c_i   (q_i),
        .o_o   (q_o)
      );

      // Strobe follows the two multiplier stages
      always_ff @(posedge clk) begin
        if (reset) begin
          stb_dly <= 2'b00;
        end else begin
          stb_dly <= {stb_dly[0], stb_i};
        end
      end

      assign stb_o = stb_dly[1];

      a_stb_latency: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset, 1) && !$past(reset, 2)) |-> (stb_o == $past(stb_i, 2)));
    end else begin : g_bypass
      // Samples move up to the wide format unchanged
      assign stb_o = stb_i;
      assign i_o   = {i_i, {`TXF_FRAC_DROP{1'b0}}};
      assign q_o   = {q_i, {`TXF_FRAC_DROP{1'b0}}};
    end
  endgenerate

endmodule

`default_nettype wire

// File: rtl/mult_add_clip.sv
/* Fixed point a*b+c with floor truncation to Q1.23 and saturation,
   two register stages */

`timescale 1ns/1ns
`default_nettype none

module mult_add_clip (
  input  logic                    clk,
  input  logic                    reset,
  input  tx_frontend_pkg::sample_t a_i,
  input  tx_frontend_pkg::corr_t   b_i,
  input  tx_frontend_pkg::sample_t c_i,
  output tx_frontend_pkg::wide_t   o_o
);

  // Product is Q2.32, output is Q1.23
  localparam int SHIFT = 9;

  logic signed [33:0] prod_q;
  tx_frontend_pkg::sample_t c_q;

  logic signed [34:0] prod_ext;
  logic signed [34:0] c_align;
  logic signed [34:0] sum_w;
  logic signed [25:0] trunc_w;
  tx_frontend_pkg::wide_t sat_w;

  // Stage 1 registers the product and the addend
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '0;
      c_q    <= '0;
    end else begin
      prod_q <= a_i * b_i;
      c_q    <= c_i;
    end
  end

  // Q1.15 addend moved up to the 32 fraction bits of the product
  assign c_align  = {{2{c_q[15]}}, c_q, 17'd0};
  assign prod_ext = {prod_q[33], prod_q};
  assign sum_w    = prod_ext + c_align;

  // Dropping the low bits floors toward minus infinity
  assign trunc_w = sum_w[34:SHIFT];

  always_comb begin
    if (trunc_w[25:23] == 3'b000 || trunc_w[25:23] == 3'b111) begin
      sat_w = trunc_w[23:0];
    end else if (trunc_w[25]) begin
      sat_w = {1'b1, {23{1'b0}}};
    end else begin
      sat_w = {1'b0, {23{1'b1}}};
    end
  end

  // Stage 2 holds the clipped result
  always_ff @(posedge clk) begin
    if (reset) begin
      o_o <= '0;
    end else begin
      o_o <= sat_w;
    end
  end

endmodule

`default_nettype wire

// File: rtl/setting_reg.sv
/* Settings bus register holding one payload of any packed type */

`timescale 1ns/1ns
`default_nettype none

`include "tx_frontend_macros.svh"

module setting_reg #(
  parameter type payload_t = logic [7:0],
  parameter logic [`TXF_SET_ADDR_W-1:0] ADDR = '0,
  parameter payload_t RESET_VAL = payload_t'(0)
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set_stb_i,
  input  logic [`TXF_SET_ADDR_W-1:0] set_addr_i,
  input  logic [`TXF_SET_DATA_W-1:0] set_data_i,
  output payload_t                   value_o
);

  localparam int PAYLOAD_W = $bits(payload_t);

  logic hit;

  // Address decode for this register
  assign hit = set_stb_i && (set_addr_i == ADDR);

  // Payload comes from the low bits of the data word
  always_ff @(posedge clk) begin
    if (reset) begin
      value_o <= RESET_VAL;
    end else if (hit) begin
      value_o <= payload_t'(set_data_i[PAYLOAD_W-1:0]);
    end
  end

endmodule

`default_nettype wire

// File: rtl/tx_frontend_pkg.sv
/* Sample, wide sample, correction and mux control types */

`default_nettype none

package tx_frontend_pkg;

  // Q1.15 baseband sample
  typedef logic signed [15:0] sample_t;

  // Q1.23 intermediate sample, 8 extra fraction bits
  typedef logic signed [23:0] wide_t;

  // Q1.17 correction coefficient
  typedef logic signed [17:0] corr_t;

  // High nibble routes DAC Q, low nibble routes DAC I
  typedef struct packed {
    logic [3:0] q_sel;
    logic [3:0] i_sel;
  } mux_ctrl_t;

  // Source codes for one mux nibble, anything else gives zero
  localparam logic [3:0] MUX_SEL_I = 4'd0;
  localparam logic [3:0] MUX_SEL_Q = 4'd1;

endpackage

`default_nettype wire

// File: include/tx_frontend_macros.svh
/* Settings addresses, mux reset value, bus and data widths,
   and default bypass choices for the transmit front end */

`ifndef TX_FRONTEND_MACROS_SVH
`define TX_FRONTEND_MACROS_SVH

// Settings register addresses
`define TXF_SR_OFFSET_I    0
`define TXF_SR_OFFSET_Q    1
`define TXF_SR_MAG_CORR    2
`define TXF_SR_PHASE_CORR  3
`define TXF_SR_MUX         4

// DAC I takes I, DAC Q takes Q
`define TXF_MUX_RESET      8'h10

// Settings bus widths
`define TXF_SET_ADDR_W     8
`define TXF_SET_DATA_W     32

// Bits removed when going from wide_t back to sample_t
`define TXF_FRAC_DROP      8

// Both correction stages are in the path by default
`define TXF_BYPASS_IQ_COMP         0
`define TXF_BYPASS_DC_OFFSET_CORR  0

`endif
